/* tb.f */
common/lc4_isa_pkg.sv
common/pipe_pkg.sv
common/fwd_if.sv
hw/fetch_unit.sv
issue/lc4_decoder.sv
issue/lc4_regfile2w.sv
issue/issue_ctrl.sv
hw/exec_stage.sv
hw/mem_wb_stage.sv
hw/lc4_superscalar.sv
sim/store_checker.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top \
   -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0

/* sim/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top
   import lc4_isa_pkg::*;
();

   localparam word_t RESET_PC = 16'h8200;
   localparam int    NTEST    = 6;
   localparam int    MAXP     = 80;

   logic  gwe;
   logic  rst_n;
   word_t insn_a;
   word_t insn_b;
   word_t dmem_rdata;
   word_t cur_pc;
   word_t dmem_addr;
   word_t dmem_towrite;
   logic  dmem_we;

   word_t prog [NTEST][MAXP];
   int    prog_len [NTEST];
   word_t imem [MAXP];
   word_t dmem [65536];
   word_t ref_mem [65536];
   word_t exp_addr [128];
   word_t exp_data [128];
   int    exp_count;
   int    test_num;
   logic  test_end;
   int    seed;
   int    cyc;
   int    cyc_limit;
   int    seen;
   int    pass_cnt;
   int    fail_cnt;

   lc4_superscalar #(.RESET_PC(RESET_PC)) dut0 (
      .gwe            (gwe),
      .i_rst_n        (rst_n),
      .o_cur_pc       (cur_pc),
      .i_insn_a       (insn_a),
      .i_insn_b       (insn_b),
      .o_dmem_addr    (dmem_addr),
      .i_dmem_data    (dmem_rdata),
      .o_dmem_we      (dmem_we),
      .o_dmem_towrite (dmem_towrite)
   );

   store_checker #(.RESET_PC(RESET_PC)) chk (
      .gwe            (gwe),
      .i_rst_n        (rst_n),
      .i_pc           (cur_pc),
      .i_dmem_we      (dmem_we),
      .i_dmem_addr    (dmem_addr),
      .i_dmem_towrite (dmem_towrite),
      .i_test_num     (test_num),
      .i_exp_count    (exp_count),
      .i_exp_addr     (exp_addr),
      .i_exp_data     (exp_data),
      .i_test_end     (test_end),
      .o_seen         (seen),
      .o_pass_cnt     (pass_cnt),
      .o_fail_cnt     (fail_cnt)
   );

   always #50 gwe = ~gwe;

   function automatic word_t fill_word(int a);
      word_t w;
      w = 16'(a);
      return {w[7:0], w[15:8]} ^ 16'h3c5a;  // byte swap keeps every bit in play
   endfunction

   function automatic word_t imem_word(word_t pc);
      word_t off;
      off = pc - RESET_PC;
      if (off < MAXP) return imem[off];
      return 16'h0000;
   endfunction

   function automatic word_t enc_rr(logic [3:0] opc, logic [2:0] sub, int d, int s, int t);
      return {opc, 3'(d), 3'(s), sub, 3'(t)};
   endfunction

   function automatic word_t enc_addi(int d, int s, int imm);
      return {4'b0001, 3'(d), 3'(s), 1'b1, 5'(imm)};
   endfunction

   function automatic word_t enc_mem(logic [3:0] opc, int r, int s, int off);
      return {opc, 3'(r), 3'(s), 6'(off)};  // LDR rd or STR rt in bits 11:9
   endfunction

   function automatic word_t enc_const(int d, int imm);
      return {4'b1001, 3'(d), 9'(imm)};
   endfunction

   function automatic int urand(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   task automatic add_insn(int t, word_t w);
      prog[t][prog_len[t]] = w;
      prog_len[t]++;
   endtask

   task automatic build_programs();
      int k;
      for (int t = 0; t < NTEST; t++) prog_len[t] = 0;
      // independent ops, stores pull from M and W
      add_insn(1, enc_const(0, 5));
      add_insn(1, enc_const(1, -3));
      add_insn(1, enc_const(2, 100));
      add_insn(1, enc_const(3, 7));
      add_insn(1, enc_rr(4'b0001, 3'b000, 4, 0, 1));
      add_insn(1, enc_rr(4'b0001, 3'b010, 5, 2, 3));
      add_insn(1, enc_rr(4'b0001, 3'b001, 6, 0, 2));
      add_insn(1, enc_rr(4'b0101, 3'b011, 3, 1, 2));
      add_insn(1, enc_rr(4'b0101, 3'b000, 0, 2, 1));
      add_insn(1, enc_const(7, 64));
      add_insn(1, enc_mem(4'b0111, 4, 7, 0));
      add_insn(1, enc_rr(4'b0101, 3'b010, 1, 5, 6));
      add_insn(1, enc_mem(4'b0111, 5, 7, 1));
      add_insn(1, enc_mem(4'b0111, 6, 7, 2));
      add_insn(1, enc_mem(4'b0111, 3, 7, 3));
      add_insn(1, enc_mem(4'b0111, 0, 7, 4));
      add_insn(1, enc_mem(4'b0111, 1, 7, 5));
      // B reads A, then both write r3
      add_insn(2, enc_const(1, 3));
      add_insn(2, enc_rr(4'b0001, 3'b000, 1, 1, 1));
      add_insn(2, enc_rr(4'b0001, 3'b000, 2, 1, 1));
      add_insn(2, enc_addi(3, 2, 1));
      add_insn(2, enc_const(3, 2));
      add_insn(2, enc_rr(4'b0001, 3'b001, 2, 2, 1));
      add_insn(2, enc_addi(2, 2, -1));
      add_insn(2, enc_const(7, 64));
      add_insn(2, enc_mem(4'b0111, 1, 7, 0));
      add_insn(2, enc_mem(4'b0111, 2, 7, 1));
      add_insn(2, enc_mem(4'b0111, 3, 7, 2));
      // loads followed by users and stores
      add_insn(3, enc_const(7, 64));
      add_insn(3, enc_const(1, 9));
      add_insn(3, enc_mem(4'b0111, 1, 7, 0));
      add_insn(3, enc_mem(4'b0110, 2, 7, 0));
      add_insn(3, enc_rr(4'b0001, 3'b000, 3, 2, 2));
      add_insn(3, enc_mem(4'b0110, 4, 7, 5));
      add_insn(3, enc_mem(4'b0111, 4, 7, 1));
      add_insn(3, enc_mem(4'b0110, 5, 7, 0));
      add_insn(3, enc_mem(4'b0111, 5, 7, 2));
      add_insn(3, enc_mem(4'b0110, 6, 7, 1));
      add_insn(3, enc_addi(6, 6, 3));
      add_insn(3, enc_mem(4'b0111, 6, 7, 3));
      add_insn(3, enc_mem(4'b0111, 3, 7, 4));
      // back to back memory ops
      add_insn(4, enc_const(7, 64));
      add_insn(4, enc_const(1, 11));
      add_insn(4, enc_const(2, 22));
      add_insn(4, enc_mem(4'b0111, 1, 7, 0));
      add_insn(4, enc_mem(4'b0111, 2, 7, 1));
      add_insn(4, enc_mem(4'b0111, 1, 7, 2));
      add_insn(4, enc_mem(4'b0110, 3, 7, 0));
      add_insn(4, enc_mem(4'b0110, 4, 7, 1));
      add_insn(4, enc_mem(4'b0111, 3, 7, 3));
      add_insn(4, enc_mem(4'b0111, 4, 7, 4));
      add_insn(4, enc_mem(4'b0110, 5, 7, 3));
      add_insn(4, enc_mem(4'b0111, 5, 7, 5));
      add_insn(4, enc_mem(4'b0111, 5, 7, 6));
      // r7 stays the data base, offsets span 32..95
      add_insn(5, enc_const(7, 64));
      for (int i = 0; i < 60; i++) begin
         k = urand(10);
         case (k)
            0: add_insn(5, enc_rr(4'b0001, 3'b000, urand(7), urand(8), urand(8)));
            1: add_insn(5, enc_rr(4'b0001, 3'b001, urand(7), urand(8), urand(8)));
            2: add_insn(5, enc_rr(4'b0001, 3'b010, urand(7), urand(8), urand(8)));
            3: add_insn(5, enc_addi(urand(7), urand(8), urand(32)));
            4: add_insn(5, enc_rr(4'b0101, 3'b000, urand(7), urand(8), urand(8)));
            5: add_insn(5, enc_rr(4'b0101, 3'b010, urand(7), urand(8), urand(8)));
            6: add_insn(5, enc_rr(4'b0101, 3'b011, urand(7), urand(8), urand(8)));
            7: add_insn(5, enc_mem(4'b0110, urand(7), 7, urand(64)));
            8: add_insn(5, enc_mem(4'b0111, urand(8), 7, urand(64)));
            default: add_insn(5, enc_const(urand(7), urand(512)));
         endcase
      end
   endtask

   // sequential interpreter, one instruction at a time
   function automatic int ref_run(int t);
      word_t r [8];
      word_t w;
      word_t a;
      word_t s;
      word_t v;
      int    n;
      n = 0;
      for (int i = 0; i < 8; i++) r[i] = '0;
      for (int i = 0; i < prog_len[t]; i++) begin
         w = prog[t][i];
         s = r[w[8:6]];
         v = r[w[2:0]];
         a = s + {{10{w[5]}}, w[5:0]};
         case (w[15:12])
            4'b0001: begin
               if (w[5]) r[w[11:9]] = s + {{11{w[4]}}, w[4:0]};
               else if (w[5:3] == 3'b000) r[w[11:9]] = s + v;
               else if (w[5:3] == 3'b001) r[w[11:9]] = s * v;
               else if (w[5:3] == 3'b010) r[w[11:9]] = s - v;
            end
            4'b0101: begin
               if (w[5:3] == 3'b000) r[w[11:9]] = s & v;
               else if (w[5:3] == 3'b010) r[w[11:9]] = s | v;
               else if (w[5:3] == 3'b011) r[w[11:9]] = s ^ v;
            end
            4'b0110: r[w[11:9]] = ref_mem[a];
            4'b0111: begin
               ref_mem[a]  = r[w[11:9]];
               exp_addr[n] = a;
               exp_data[n] = r[w[11:9]];
               n++;
            end
            4'b1001: r[w[11:9]] = {{7{w[8]}}, w[8:0]};
            default: ;
         endcase
      end
      return n;
   endfunction

   // memories answer combinationally, driven on the falling edge
   always @(negedge gwe) begin
      if (rst_n && dmem_we) dmem[dmem_addr] = dmem_towrite;
      insn_a     = imem_word(cur_pc);
      insn_b     = imem_word(cur_pc + 16'd1);
      dmem_rdata = dmem[dmem_addr];
   end

   always @(posedge gwe) begin
      cyc = cyc + 1;
      if (cyc_limit > 0 && cyc > cyc_limit) begin
         $display("timeout after %0d cycles, the pipeline stopped making progress", cyc);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic run_test(int t);
      @(negedge gwe);
      rst_n    = 1'b0;
      test_num = t;
      for (int a = 0; a < 65536; a++) begin
         dmem[a]    = fill_word(a);
         ref_mem[a] = fill_word(a);
      end
      for (int i = 0; i < MAXP; i++) imem[i] = (i < prog_len[t]) ? prog[t][i] : 16'h0000;
      exp_count = ref_run(t);
      repeat (8) @(negedge gwe);
      rst_n = 1'b1;
      while (!(int'(16'(cur_pc - RESET_PC)) >= prog_len[t] && seen == exp_count)) begin
         @(negedge gwe);
      end
      repeat (8) @(negedge gwe);  // drain so extra stores show up
      test_end = 1'b1;
      @(negedge gwe);
      test_end = 1'b0;
   endtask

   initial begin
      gwe        = 1'b0;
      rst_n      = 1'b0;
      insn_a     = '0;
      insn_b     = '0;
      dmem_rdata = '0;
      test_end   = 1'b0;
      test_num   = 0;
      exp_count  = 0;
      seed       = 24;
      cyc        = 0;
      cyc_limit  = 0;
      for (int i = 0; i < 128; i++) begin
         exp_addr[i] = '0;
         exp_data[i] = '0;
      end
      build_programs();
      // four cycles per instruction plus 20, and reset, drain and end cycles
      for (int t = 0; t < NTEST; t++) cyc_limit += 4 * prog_len[t] + 20 + 18;
      for (int t = 0; t < NTEST; t++) run_test(t);
      @(negedge gwe);
      $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim/store_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module store_checker
   import lc4_isa_pkg::*;
#(
   parameter word_t RESET_PC = 16'h8200
) (
   input  wire             gwe,
   input  wire             i_rst_n,
   input  wire word_t      i_pc,
   input  wire             i_dmem_we,
   input  wire word_t      i_dmem_addr,
   input  wire word_t      i_dmem_towrite,
   input  wire [31:0]      i_test_num,
   input  wire [31:0]      i_exp_count,
   input  wire word_t      i_exp_addr [128],
   input  wire word_t      i_exp_data [128],
   input  wire             i_test_end,   // high for one cycle after the drain
   output int              o_seen,
   output int              o_pass_cnt,
   output int              o_fail_cnt
);

   int   errs;
   logic first_edge;

   function automatic string test_name(int n);
      case (n)
         0:       return "reset";
         1:       return "independent";
         2:       return "dependent";
         3:       return "load_use";
         4:       return "mem_runs";
         default: return "random";
      endcase
   endfunction

   initial begin
      o_seen     = 0;
      o_pass_cnt = 0;
      o_fail_cnt = 0;
      errs       = 0;
      first_edge = 1'b0;
      forever begin
         @(posedge gwe);
         if (!i_rst_n) begin
            if (!first_edge) begin
               // reset just began, counts start over
               o_seen = 0;
               errs   = 0;
            end else begin
               if (i_dmem_we) begin
                  $display("Fail %s: dmem_we expected 0 actual 1 in reset",
                           test_name(i_test_num));
                  errs++;
               end
               if (i_pc != RESET_PC) begin
                  $display("Fail %s: pc expected %h actual %h in reset",
                           test_name(i_test_num), RESET_PC, i_pc);
                  errs++;
               end
            end
            first_edge = 1'b1;
         end else begin
            // pc seen here is still the reset value
            if (first_edge && i_pc != RESET_PC) begin
               $display("Fail %s: pc expected %h actual %h at first edge",
                        test_name(i_test_num), RESET_PC, i_pc);
               errs++;
            end
            first_edge = 1'b0;
            if (i_dmem_we) begin
               if (o_seen >= int'(i_exp_count)) begin
                  $display("%s: unexpected extra store to %h with data %h",
                           test_name(i_test_num), i_dmem_addr, i_dmem_towrite);
                  errs++;
               end else if (i_dmem_addr != i_exp_addr[o_seen] ||
                            i_dmem_towrite != i_exp_data[o_seen]) begin
                  $display("Fail %s: store %0d expected %h:%h actual %h:%h",
                           test_name(i_test_num), o_seen, i_exp_addr[o_seen],
                           i_exp_data[o_seen], i_dmem_addr, i_dmem_towrite);
                  errs++;
               end
               o_seen++;
            end
            if (i_test_end) begin
               if (o_seen < int'(i_exp_count)) begin
                  $display("%s: only %0d of %0d expected stores appeared",
                           test_name(i_test_num), o_seen, i_exp_count);
                  errs++;
               end
               if (errs == 0) begin
                  $display("test %s: ok, %0d stores", test_name(i_test_num), o_seen);
                  o_pass_cnt++;
               end else begin
                  $display("test %s: %0d errors", test_name(i_test_num), errs);
                  o_fail_cnt++;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* hw/lc4_superscalar.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_superscalar
   import lc4_isa_pkg::*, pipe_pkg::*;
#(
   parameter word_t RESET_PC = 16'h8200
) (
   input  wire        gwe,
   input  wire        i_rst_n,
   output word_t      o_cur_pc,        // imem reads o_cur_pc and o_cur_pc + 1
   input  wire word_t i_insn_a,
   input  wire word_t i_insn_b,
   output word_t      o_dmem_addr,
   input  wire word_t i_dmem_data,
   output logic       o_dmem_we,
   output word_t      o_dmem_towrite
);

   issue_e    issue;
   word_t     d_insn_a;
   word_t     d_insn_b;
   decoded_t  x_dec_a;
   decoded_t  x_dec_b;
   word_t     x_rs_a;
   word_t     x_rt_a;
   word_t     x_rs_b;
   word_t     x_rt_b;
   x_result_t res_a;
   x_result_t res_b;

   fwd_if fwd ();

   fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_issue    (issue),
      .i_insn_a   (i_insn_a),
      .i_insn_b   (i_insn_b),
      .o_pc       (o_cur_pc),
      .o_d_insn_a (d_insn_a),
      .o_d_insn_b (d_insn_b)
   );

   issue_ctrl u_issue (
      .gwe        (gwe),
      .i_rst_n    (i_rst_n),
      .i_d_insn_a (d_insn_a),
      .i_d_insn_b (d_insn_b),
      .i_x_dec_a  (res_a.dec),  // X-stage loads for the load-use check
      .i_x_dec_b  (res_b.dec),
      .o_issue    (issue),
      .o_x_dec_a  (x_dec_a),
      .o_x_dec_b  (x_dec_b),
      .o_x_rs_a   (x_rs_a),
      .o_x_rt_a   (x_rt_a),
      .o_x_rs_b   (x_rs_b),
      .o_x_rt_b   (x_rt_b),
      .wb         (fwd)
   );

   exec_stage u_exec (
      .i_x_dec_a (x_dec_a),
      .i_x_dec_b (x_dec_b),
      .i_x_rs_a  (x_rs_a),
      .i_x_rt_a  (x_rt_a),
      .i_x_rs_b  (x_rs_b),
      .i_x_rt_b  (x_rt_b),
      .fwd       (fwd),
      .o_res_a   (res_a),
      .o_res_b   (res_b)
   );

   mem_wb_stage u_mem_wb (
      .gwe            (gwe),
      .i_rst_n        (i_rst_n),
      .i_res_a        (res_a),
      .i_res_b        (res_b),
      .o_dmem_addr    (o_dmem_addr),
      .o_dmem_we      (o_dmem_we),
      .o_dmem_towrite (o_dmem_towrite),
      .i_dmem_data    (i_dmem_data),
      .fwd            (fwd)
   );

endmodule

`default_nettype wire

/* hw/mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage
   import lc4_isa_pkg::*, pipe_pkg::*;
(
   input  wire            gwe,
   input  wire            i_rst_n,
   input  wire x_result_t i_res_a,
   input  wire x_result_t i_res_b,
   output word_t          o_dmem_addr,
   output logic           o_dmem_we,
   output word_t          o_dmem_towrite,
   input  wire word_t     i_dmem_data,
   fwd_if.producer        fwd
);

   x_result_t m_a;
   x_result_t m_b;
   decoded_t  w_dec_a;
   decoded_t  w_dec_b;
   word_t     w_res_a;
   word_t     w_res_b;
   word_t     w_ld;     // one port, so one loaded word per cycle
   logic      mem_a;
   logic      mem_b;
   reg_sel_t  st_rt;
   word_t     st_data;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         m_a     <= X_NOP;
         m_b     <= X_NOP;
         w_dec_a <= DEC_NOP;
         w_dec_b <= DEC_NOP;
      end else begin
         m_a     <= i_res_a;
         m_b     <= i_res_b;
         w_dec_a <= m_a.dec;
         w_dec_b <= m_b.dec;
      end
   end

   always_ff @(posedge gwe) begin
      w_res_a <= m_a.alu_res;
      w_res_b <= m_b.alu_res;
      w_ld    <= i_dmem_data;
   end

   assign mem_a = m_a.dec.is_load || m_a.dec.is_store;
   assign mem_b = m_b.dec.is_load || m_b.dec.is_store;

   // X forwarded the load address for these, fix up with the data
   always_comb begin
      st_rt   = m_a.dec.is_store ? m_a.dec.rt : m_b.dec.rt;
      st_data = m_a.dec.is_store ? m_a.st_data : m_b.st_data;
      if (w_dec_b.rd_we && w_dec_b.rd == st_rt) begin
         if (w_dec_b.is_load) st_data = w_ld;
      end else if (w_dec_a.rd_we && w_dec_a.rd == st_rt && w_dec_a.is_load) begin
         st_data = w_ld;
      end
      if (m_b.dec.is_store && m_a.dec.rd_we && m_a.dec.rd == st_rt) begin
         st_data = m_a.alu_res;  // pair-mate wrote B's rt
      end
   end

   assign o_dmem_addr    = mem_a ? m_a.alu_res : mem_b ? m_b.alu_res : '0;
   assign o_dmem_we      = m_a.dec.is_store || m_b.dec.is_store;
   assign o_dmem_towrite = st_data;

   assign fwd.m_rd_a   = m_a.dec.rd;
   assign fwd.m_we_a   = m_a.dec.rd_we;
   assign fwd.m_res_a  = m_a.alu_res;
   assign fwd.m_rd_b   = m_b.dec.rd;
   assign fwd.m_we_b   = m_b.dec.rd_we;
   assign fwd.m_res_b  = m_b.alu_res;
   assign fwd.w_rd_a   = w_dec_a.rd;
   assign fwd.w_we_a   = w_dec_a.rd_we;
   assign fwd.w_data_a = w_dec_a.is_load ? w_ld : w_res_a;
   assign fwd.w_rd_b   = w_dec_b.rd;
   assign fwd.w_we_b   = w_dec_b.rd_we;
   assign fwd.w_data_b = w_dec_b.is_load ? w_ld : w_res_b;

   // the structural check in D must keep stores apart
   m_one_store: assert property (@(posedge gwe) disable iff (!i_rst_n)
      !(m_a.dec.is_store && m_b.dec.is_store));

endmodule

`default_nettype wire

/* hw/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage
   import lc4_isa_pkg::*, pipe_pkg::*;
(
   input  wire decoded_t i_x_dec_a,
   input  wire decoded_t i_x_dec_b,
   input  wire word_t    i_x_rs_a,
   input  wire word_t    i_x_rt_a,
   input  wire word_t    i_x_rs_b,
   input  wire word_t    i_x_rt_b,
   fwd_if.bypass         fwd,
   output x_result_t     o_res_a,
   output x_result_t     o_res_b
);

   reg_sel_t op_sel [4];  // rs_a, rt_a, rs_b, rt_b
   word_t    op_rf  [4];
   word_t    op_val [4];

   function automatic word_t alu(decoded_t d, word_t rs, word_t rt);
      word_t b;
      b = d.use_imm ? d.imm : rt;
      case (d.alu_op)
         ALU_ADD,
         ALU_ADDR:     return rs + b;
         ALU_MUL:      return rs * b;  // low 16 bits only
         ALU_SUB:      return rs - b;
         ALU_AND:      return rs & b;
         ALU_OR:       return rs | b;
         ALU_XOR:      return rs ^ b;
         ALU_PASS_IMM: return d.imm;
         default:      return '0;
      endcase
   endfunction

   assign op_sel = '{i_x_dec_a.rs, i_x_dec_a.rt, i_x_dec_b.rs, i_x_dec_b.rt};
   assign op_rf  = '{i_x_rs_a, i_x_rt_a, i_x_rs_b, i_x_rt_b};

   // youngest producer first
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         if (fwd.m_we_b && fwd.m_rd_b == op_sel[i]) begin
            op_val[i] = fwd.m_res_b;
         end else if (fwd.m_we_a && fwd.m_rd_a == op_sel[i]) begin
            op_val[i] = fwd.m_res_a;
         end else if (fwd.w_we_b && fwd.w_rd_b == op_sel[i]) begin
            op_val[i] = fwd.w_data_b;
         end else if (fwd.w_we_a && fwd.w_rd_a == op_sel[i]) begin
            op_val[i] = fwd.w_data_a;
         end else begin
            op_val[i] = op_rf[i];  // regfile value read in D
         end
      end
   end

   assign o_res_a = '{
      dec:     i_x_dec_a,
      alu_res: alu(i_x_dec_a, op_val[0], op_val[1]),
      st_data: op_val[1]
   };

   assign o_res_b = '{
      dec:     i_x_dec_b,
      alu_res: alu(i_x_dec_b, op_val[2], op_val[3]),
      st_data: op_val[3]
   };

endmodule

`default_nettype wire

/* issue/issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl
   import lc4_isa_pkg::*, pipe_pkg::*;
(
   input  wire           gwe,
   input  wire           i_rst_n,
   input  wire word_t    i_d_insn_a,
   input  wire word_t    i_d_insn_b,
   input  wire decoded_t i_x_dec_a,   // what sits in X right now
   input  wire decoded_t i_x_dec_b,
   output issue_e        o_issue,
   output decoded_t      o_x_dec_a,
   output decoded_t      o_x_dec_b,
   output word_t         o_x_rs_a,
   output word_t         o_x_rt_a,
   output word_t         o_x_rs_b,
   output word_t         o_x_rt_b,
   fwd_if.writeback      wb
);

   decoded_t dec_a;
   decoded_t dec_b;
   reg_sel_t rsel  [4];
   word_t    rdata [4];
   logic     lu_a;
   logic     lu_b;
   logic     ab_dep;
   logic     mem_a;
   logic     mem_b;

   // store data is patched in M, so a store's rt never stalls
   function automatic logic load_use(decoded_t d, decoded_t x);
      return x.is_load &&
             ((d.rs_re && d.rs == x.rd) || (d.rt_re && !d.is_store && d.rt == x.rd));
   endfunction

   lc4_decoder u_dec_a (.i_insn(i_d_insn_a), .o_dec(dec_a));
   lc4_decoder u_dec_b (.i_insn(i_d_insn_b), .o_dec(dec_b));

   assign rsel = '{dec_a.rs, dec_a.rt, dec_b.rs, dec_b.rt};

   lc4_regfile2w u_rf (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rsel    (rsel),
      .o_rdata   (rdata),
      .i_wsel_a  (wb.w_rd_a),
      .i_wsel_b  (wb.w_rd_b),
      .i_we_a    (wb.w_we_a),
      .i_we_b    (wb.w_we_b),
      .i_wdata_a (wb.w_data_a),
      .i_wdata_b (wb.w_data_b)
   );

   assign lu_a   = load_use(dec_a, i_x_dec_a) || load_use(dec_a, i_x_dec_b);
   assign lu_b   = load_use(dec_b, i_x_dec_a) || load_use(dec_b, i_x_dec_b);
   assign ab_dep = dec_a.rd_we &&
                   ((dec_b.rs_re && dec_b.rs == dec_a.rd) ||
                    (dec_b.rt_re && !dec_b.is_store && dec_b.rt == dec_a.rd));
   assign mem_a  = dec_a.is_load || dec_a.is_store;
   assign mem_b  = dec_b.is_load || dec_b.is_store;

   always_comb begin
      if (lu_a) begin
         o_issue = ISSUE_NONE;
      end else if (ab_dep || lu_b || (mem_a && mem_b)) begin
         o_issue = ISSUE_A_ONLY;  // one dmem port per pair
      end else begin
         o_issue = ISSUE_BOTH;
      end
   end

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_x_dec_a <= DEC_NOP;
         o_x_dec_b <= DEC_NOP;
      end else begin
         o_x_dec_a <= (o_issue == ISSUE_NONE) ? DEC_NOP : dec_a;  // bubble
         o_x_dec_b <= (o_issue == ISSUE_BOTH) ? dec_b : DEC_NOP;
      end
   end

   always_ff @(posedge gwe) begin
      o_x_rs_a <= rdata[0];
      o_x_rt_a <= rdata[1];
      o_x_rs_b <= rdata[2];
      o_x_rt_b <= rdata[3];
   end

   // a dual issue never carries two memory ops into X
   x_one_mem: assert property (@(posedge gwe) disable iff (!i_rst_n)
      (o_issue == ISSUE_BOTH) |=>
         !((o_x_dec_a.is_load || o_x_dec_a.is_store) &&
           (o_x_dec_b.is_load || o_x_dec_b.is_store)));

endmodule

`default_nettype wire

/* issue/lc4_regfile2w.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile2w
   import lc4_isa_pkg::*;
(
   input  wire           gwe,
   input  wire           i_rst_n,
   input  wire reg_sel_t i_rsel [4],  // rs_a, rt_a, rs_b, rt_b
   output word_t         o_rdata [4],
   input  wire reg_sel_t i_wsel_a,
   input  wire reg_sel_t i_wsel_b,
   input  wire           i_we_a,
   input  wire           i_we_b,
   input  wire word_t    i_wdata_a,
   input  wire word_t    i_wdata_b
);

   word_t regs [8];

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (i_we_a) regs[i_wsel_a] <= i_wdata_a;
         if (i_we_b) regs[i_wsel_b] <= i_wdata_b;  // second write wins on a tie
      end
   end

   // same-cycle write is visible to D, B is the younger one
   always_comb begin
      for (int p = 0; p < 4; p++) begin
         if (i_we_b && i_wsel_b == i_rsel[p]) begin
            o_rdata[p] = i_wdata_b;
         end else if (i_we_a && i_wsel_a == i_rsel[p]) begin
            o_rdata[p] = i_wdata_a;
         end else begin
            o_rdata[p] = regs[i_rsel[p]];
         end
      end
   end

endmodule

`default_nettype wire

/* issue/lc4_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module lc4_decoder
   import lc4_isa_pkg::*;
(
   input  wire word_t i_insn,
   output decoded_t   o_dec
);

   opcode_e opc;
   alu_op_e rr_alu;   // op of the register-register forms
   logic    rr_ok;
   word_t   imm5;
   word_t   imm6;
   word_t   imm9;

   assign opc  = opcode_e'(i_insn[15:12]);
   assign imm5 = {{11{i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{7{i_insn[8]}}, i_insn[8:0]};

   // bit 14 tells LOGIC from ARITH
   always_comb begin
      rr_ok  = 1'b1;
      rr_alu = ALU_ADD;
      case ({i_insn[14], i_insn[5:3]})
         4'b0_000: rr_alu = ALU_ADD;
         4'b0_001: rr_alu = ALU_MUL;
         4'b0_010: rr_alu = ALU_SUB;
         4'b1_000: rr_alu = ALU_AND;
         4'b1_010: rr_alu = ALU_OR;
         4'b1_011: rr_alu = ALU_XOR;
         default:  rr_ok  = 1'b0;  // DIV, NOT, ANDI are dropped
      endcase
   end

   always_comb begin
      o_dec = DEC_NOP;
      case (opc)
         OP_ARITH, OP_LOGIC: begin
            if (opc == OP_ARITH && i_insn[5]) begin  // ADDI
               o_dec.rs      = i_insn[8:6];
               o_dec.rs_re   = 1'b1;
               o_dec.rd      = i_insn[11:9];
               o_dec.rd_we   = 1'b1;
               o_dec.imm     = imm5;
               o_dec.use_imm = 1'b1;
            end else if (rr_ok) begin
               o_dec.rs     = i_insn[8:6];
               o_dec.rs_re  = 1'b1;
               o_dec.rt     = i_insn[2:0];
               o_dec.rt_re  = 1'b1;
               o_dec.rd     = i_insn[11:9];
               o_dec.rd_we  = 1'b1;
               o_dec.alu_op = rr_alu;
            end
         end
         OP_LDR: begin
            o_dec.rs      = i_insn[8:6];
            o_dec.rs_re   = 1'b1;
            o_dec.rd      = i_insn[11:9];
            o_dec.rd_we   = 1'b1;
            o_dec.is_load = 1'b1;
            o_dec.alu_op  = ALU_ADDR;
            o_dec.imm     = imm6;
            o_dec.use_imm = 1'b1;
         end
         OP_STR: begin
            o_dec.rs       = i_insn[8:6];
            o_dec.rs_re    = 1'b1;
            o_dec.rt       = i_insn[11:9];  // data register sits in the rd field
            o_dec.rt_re    = 1'b1;
            o_dec.is_store = 1'b1;
            o_dec.alu_op   = ALU_ADDR;
            o_dec.imm      = imm6;
            o_dec.use_imm  = 1'b1;
         end
         OP_CONST: begin
            o_dec.rd      = i_insn[11:9];
            o_dec.rd_we   = 1'b1;
            o_dec.alu_op  = ALU_PASS_IMM;
            o_dec.imm     = imm9;
            o_dec.use_imm = 1'b1;
         end
         default: o_dec = DEC_NOP;
      endcase
   end

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
   import lc4_isa_pkg::*, pipe_pkg::*;
#(
   parameter word_t RESET_PC = 16'h8200
) (
   input  wire         gwe,
   input  wire         i_rst_n,
   input  wire issue_e i_issue,   // decision for the pair now in D
   input  wire word_t  i_insn_a,  // imem word at o_pc
   input  wire word_t  i_insn_b,  // imem word at o_pc + 1
   output word_t       o_pc,
   output word_t       o_d_insn_a,
   output word_t       o_d_insn_b
);

   word_t pc;
   word_t d_a;
   word_t d_b;

   always_ff @(posedge gwe or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc  <= RESET_PC;
         d_a <= '0;  // 0000 decodes as nop
         d_b <= '0;
      end else begin
         case (i_issue)
            ISSUE_BOTH: begin
               pc  <= pc + 16'd2;
               d_a <= i_insn_a;
               d_b <= i_insn_b;
            end
            ISSUE_A_ONLY: begin
               // old B moves up, one new word behind it
               pc  <= pc + 16'd1;
               d_a <= d_b;
               d_b <= i_insn_a;
            end
            default: begin
               pc  <= pc;  // stall holds PC and D
               d_a <= d_a;
               d_b <= d_b;
            end
         endcase
      end
   end

   assign o_pc       = pc;
   assign o_d_insn_a = d_a;
   assign o_d_insn_b = d_b;

   // PC only steps by what the issue decision allows
   pc_step: assert property (@(posedge gwe) disable iff (!i_rst_n)
      word_t'(pc - $past(pc)) <= 16'd2);

endmodule

`default_nettype wire

/* common/fwd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fwd_if
   import lc4_isa_pkg::*;
();

   // M stage, per slot
   reg_sel_t m_rd_a;
   logic     m_we_a;
   word_t    m_res_a;
   reg_sel_t m_rd_b;
   logic     m_we_b;
   word_t    m_res_b;

   // W stage, data is final write-back value
   reg_sel_t w_rd_a;
   logic     w_we_a;
   word_t    w_data_a;
   reg_sel_t w_rd_b;
   logic     w_we_b;
   word_t    w_data_b;

   modport producer (
      output m_rd_a, m_we_a, m_res_a, m_rd_b, m_we_b, m_res_b,
      output w_rd_a, w_we_a, w_data_a, w_rd_b, w_we_b, w_data_b
   );

   modport bypass (
      input m_rd_a, m_we_a, m_res_a, m_rd_b, m_we_b, m_res_b,
      input w_rd_a, w_we_a, w_data_a, w_rd_b, w_we_b, w_data_b
   );

   modport writeback (
      input w_rd_a, w_we_a, w_data_a, w_rd_b, w_we_b, w_data_b
   );

endinterface

`default_nettype wire

/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

   import lc4_isa_pkg::*;

   // what leaves D this cycle
   typedef enum logic [1:0] {
      ISSUE_BOTH,
      ISSUE_A_ONLY,  // B slides into slot A
      ISSUE_NONE     // load-use on slot A
   } issue_e;

   // one slot handed from X to M
   typedef struct packed {
      decoded_t dec;
      word_t    alu_res;  // also the address of a load or store
      word_t    st_data;  // rt after X forwarding
   } x_result_t;

   localparam x_result_t X_NOP = '{dec: DEC_NOP, alu_res: '0, st_data: '0};

endpackage

`default_nettype wire

/* common/lc4_isa_pkg.sv */
`default_nettype none

package lc4_isa_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_sel_t;

   // primary opcode in insn[15:12], only the kept groups are named
   typedef enum logic [3:0] {
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_MUL,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_IMM,  // CONST
      ALU_ADDR       // base + offset for LDR and STR
   } alu_op_e;

   typedef struct packed {
      reg_sel_t rs;
      logic     rs_re;
      reg_sel_t rt;
      logic     rt_re;
      reg_sel_t rd;
      logic     rd_we;
      logic     is_load;
      logic     is_store;
      alu_op_e  alu_op;
      word_t    imm;      // sign-extended already
      logic     use_imm;  // imm takes the place of rt at the ALU
   } decoded_t;

   localparam decoded_t DEC_NOP = '{alu_op: ALU_ADD, default: '0};

endpackage

`default_nettype wire
